// File: hw/isaPkg.sv
// instruction-set package: opcode views, register, ALU operation and condition encodings
package isaPkg;

    typedef logic [7:0] byteT;

    // Z80 operand order, slot 6 is the (HL) operand which this slice does not support
    typedef enum logic [2:0] {
        regB, regC, regD, regE,
        regH, regL, regSlot6, regA
    } regIdxT;

    typedef enum logic [2:0] {
        opAdd, opAdc, opSub, opSbc,
        opAnd, opXor, opOr, opCp
    } aluOpT;

    typedef enum logic [2:0] {
        ccNz, ccZ, ccNc, ccC,
        ccPo, ccPe, ccP, ccM
    } condT;

    // values of the two top opcode bits
    localparam logic [1:0] grpLoad = 2'd0;
    localparam logic [1:0] grpAluReg = 2'd2;
    localparam logic [1:0] grpImmJp = 2'd3;

    // low three bits inside group 0 and group 3
    localparam logic [2:0] lowImm = 3'd6;
    localparam logic [2:0] lowJp = 3'd2;

    typedef struct packed {
        logic [1:0] group;
        logic [2:0] op;
        logic [2:0] src;
    } aluFormT;

    typedef struct packed {
        logic [1:0] group;
        logic [2:0] cond;
        logic [2:0] low;
    } ccFormT;

    // the same byte read as operation/source or as condition/low field
    typedef union packed {
        aluFormT aluForm;
        ccFormT  ccForm;
    } opcodeT;

endpackage

// File: hw/corePkg.sv
// datapath package: flag word, decoded control word and finished-instruction result
package corePkg;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic pv;
        logic n;
        logic c;
    } flagsT;

    typedef enum logic [1:0] {
        kindAlu,
        kindLoad,
        kindJump,
        kindNone
    } kindT;

    // one decoded instruction on its way to execute
    typedef struct packed {
        logic           valid;
        kindT           kind;
        isaPkg::aluOpT  aluOp;
        logic           useImm;
        isaPkg::regIdxT srcReg;
        isaPkg::regIdxT dstReg;
        isaPkg::condT   cond;
        isaPkg::byteT   imm;
    } ctrlT;

    // regIdx is the register written when regWrite is set
    typedef struct packed {
        logic           valid;
        logic           regWrite;
        isaPkg::regIdxT regIdx;
        isaPkg::byteT   data;
        logic           flagWrite;
        flagsT          flags;
        logic           jump;
        isaPkg::byteT   target;
    } resultT;

endpackage

// File: hw/z80Decode.sv
// opcode decoder: classifies one opcode byte and registers its control word
module z80Decode (
    input  logic           clk,
    input  logic           arstN,
    input  logic           instrValid,
    input  isaPkg::opcodeT instr,
    input  isaPkg::byteT   imm,
    output corePkg::ctrlT  decCtl
);

    corePkg::ctrlT nextCtl;

    always_comb begin
        nextCtl.valid = instrValid;
        nextCtl.kind = corePkg::kindNone;
        nextCtl.aluOp = isaPkg::aluOpT'(instr.aluForm.op);
        nextCtl.useImm = 1'b0;
        // A is read on every cycle anyway, so it is a harmless default source
        nextCtl.srcReg = isaPkg::regA;
        nextCtl.dstReg = isaPkg::regA;
        nextCtl.cond = isaPkg::condT'(instr.ccForm.cond);
        nextCtl.imm = imm;

        case (instr.aluForm.group)
            isaPkg::grpAluReg: begin
                if (instr.aluForm.src != isaPkg::regSlot6) begin
                    nextCtl.kind = corePkg::kindAlu;
                    nextCtl.srcReg = isaPkg::regIdxT'(instr.aluForm.src);
                end
            end
            isaPkg::grpLoad: begin
                // LD r,n keeps its destination in the operation field
                if (instr.ccForm.low == isaPkg::lowImm &&
                    instr.aluForm.op != isaPkg::regSlot6) begin
                    nextCtl.kind = corePkg::kindLoad;
                    nextCtl.dstReg = isaPkg::regIdxT'(instr.aluForm.op);
                end
            end
            isaPkg::grpImmJp: begin
                if (instr.ccForm.low == isaPkg::lowImm) begin
                    nextCtl.kind = corePkg::kindAlu;
                    nextCtl.useImm = 1'b1;
                end else if (instr.ccForm.low == isaPkg::lowJp) begin
                    nextCtl.kind = corePkg::kindJump;
                end
            end
            default: begin
                nextCtl.kind = corePkg::kindNone;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decCtl <= '0;
        end else begin
            decCtl <= nextCtl;
        end
    end

    // execute must never request the unsupported (HL) slot as an ALU source
    aluSrcNotSlot6: assert property (
        @(posedge clk) disable iff (!arstN)
        decCtl.valid && decCtl.kind == corePkg::kindAlu |-> decCtl.srcReg != isaPkg::regSlot6
    ) else $error("ALU control word selects register slot 6");

endmodule

// File: hw/z80Execute.sv
// execute stage: ALU with nibble carry and overflow, flag build, jump test, result register
module z80Execute (
    input  logic             clk,
    input  logic             arstN,
    input  corePkg::ctrlT    decCtl,
    output isaPkg::regIdxT   srcReg,
    input  isaPkg::byteT     srcData,
    input  isaPkg::byteT     accData,
    input  corePkg::flagsT   curFlags,
    output corePkg::resultT  exRes
);

    logic            isSub;
    logic            carryIn;
    logic            cinEff;
    isaPkg::byteT    operand;
    isaPkg::byteT    addend;
    logic [8:0]      sum;
    logic [4:0]      nibbleSum;
    logic            overflow;
    isaPkg::byteT    aluRes;
    corePkg::flagsT  aluFlags;
    logic            condTrue;
    corePkg::resultT nextRes;

    // operand read request goes straight to the register file
    assign srcReg = decCtl.srcReg;

    assign isSub = decCtl.aluOp inside {isaPkg::opSub, isaPkg::opSbc, isaPkg::opCp};
    assign carryIn = (decCtl.aluOp inside {isaPkg::opAdc, isaPkg::opSbc}) & curFlags.c;
    assign operand = decCtl.useImm ? decCtl.imm : srcData;

    // subtract as A + ~B + !borrow, so carry and half carry come out inverted
    assign addend = isSub ? ~operand : operand;
    assign cinEff = carryIn ^ isSub;
    assign sum = {1'b0, accData} + {1'b0, addend} + {8'd0, cinEff};
    assign nibbleSum = {1'b0, accData[3:0]} + {1'b0, addend[3:0]} + {4'd0, cinEff};
    assign overflow = (accData[7] == addend[7]) && (sum[7] != accData[7]);

    always_comb begin
        aluFlags = '0;
        case (decCtl.aluOp)
            isaPkg::opAnd: begin
                aluRes = accData & operand;
                aluFlags.h = 1'b1;
                aluFlags.pv = ~^aluRes;
            end
            isaPkg::opXor: begin
                aluRes = accData ^ operand;
                aluFlags.pv = ~^aluRes;
            end
            isaPkg::opOr: begin
                aluRes = accData | operand;
                aluFlags.pv = ~^aluRes;
            end
            default: begin
                aluRes = sum[7:0];
                aluFlags.h = nibbleSum[4] ^ isSub;
                aluFlags.pv = overflow;
                aluFlags.c = sum[8] ^ isSub;
            end
        endcase
        aluFlags.s = aluRes[7];
        aluFlags.z = (aluRes == 8'h00);
        aluFlags.n = isSub;
    end

    always_comb begin
        case (decCtl.cond)
            isaPkg::ccNz: condTrue = ~curFlags.z;
            isaPkg::ccZ: condTrue = curFlags.z;
            isaPkg::ccNc: condTrue = ~curFlags.c;
            isaPkg::ccC: condTrue = curFlags.c;
            isaPkg::ccPo: condTrue = ~curFlags.pv;
            isaPkg::ccPe: condTrue = curFlags.pv;
            isaPkg::ccP: condTrue = ~curFlags.s;
            default: condTrue = curFlags.s;
        endcase
    end

    always_comb begin
        nextRes = '0;
        nextRes.valid = decCtl.valid;
        nextRes.regIdx = decCtl.dstReg;
        nextRes.data = aluRes;
        nextRes.flags = curFlags;
        if (decCtl.valid) begin
            case (decCtl.kind)
                corePkg::kindAlu: begin
                    // CP only compares and leaves A as it is
                    nextRes.regWrite = (decCtl.aluOp != isaPkg::opCp);
                    nextRes.flagWrite = 1'b1;
                    nextRes.flags = aluFlags;
                end
                corePkg::kindLoad: begin
                    nextRes.regWrite = 1'b1;
                    nextRes.data = decCtl.imm;
                end
                corePkg::kindJump: begin
                    nextRes.jump = condTrue;
                    nextRes.target = decCtl.imm;
                end
                default: begin
                    nextRes.jump = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exRes <= '0;
        end else begin
            exRes <= nextRes;
        end
    end

    // a taken jump leaves registers and flags alone
    jumpWritesNothing: assert property (
        @(posedge clk) disable iff (!arstN)
        exRes.valid && exRes.jump |-> !exRes.regWrite && !exRes.flagWrite
    ) else $error("jump result carries a register or flag write");

endmodule

// File: hw/z80Result.sv
// result stage: register file and flags, write-back, operand bypass and output register
module z80Result (
    input  logic            clk,
    input  logic            arstN,
    input  corePkg::resultT exRes,
    input  isaPkg::regIdxT  srcReg,
    output isaPkg::byteT    srcData,
    output isaPkg::byteT    accData,
    output corePkg::flagsT  curFlags,
    output corePkg::resultT res
);

    // slot 6 has storage for simple indexing but is never written
    isaPkg::byteT   regs [0:7];
    corePkg::flagsT flags;
    logic           regPending;
    logic           srcHit;
    logic           accHit;
    logic           flagHit;

    assign regPending = exRes.valid && exRes.regWrite;
    assign srcHit = regPending && (exRes.regIdx == srcReg);
    assign accHit = regPending && (exRes.regIdx == isaPkg::regA);
    assign flagHit = exRes.valid && exRes.flagWrite;

    // the instruction in execute commits on the next edge, forward it now
    assign srcData = srcHit ? exRes.data : regs[srcReg];
    assign accData = accHit ? exRes.data : regs[isaPkg::regA];
    assign curFlags = flagHit ? exRes.flags : flags;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else begin
            if (regPending) begin
                regs[exRes.regIdx] <= exRes.data;
            end
            if (flagHit) begin
                flags <= exRes.flags;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            res <= '0;
        end else begin
            res <= exRes;
        end
    end

    // decode filters slot 6, so no write may ever reach it
    noSlot6Write: assert property (
        @(posedge clk) disable iff (!arstN)
        regPending |-> exRes.regIdx != isaPkg::regSlot6
    ) else $error("register write targets slot 6");

endmodule

// File: hw/z80AluSlice.sv
// top level of the 8-bit ALU slice: decode, execute and result stages in a row
module z80AluSlice (
    input  logic            clk,
    input  logic            arstN,
    input  logic            instrValid,
    input  isaPkg::opcodeT  instr,
    input  isaPkg::byteT    imm,
    output corePkg::resultT res
);

    corePkg::ctrlT   decCtl;
    corePkg::resultT exRes;
    isaPkg::regIdxT  srcReg;
    isaPkg::byteT    srcData;
    isaPkg::byteT    accData;
    corePkg::flagsT  curFlags;

    z80Decode decode0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .imm        (imm),
        .decCtl     (decCtl)
    );

    z80Execute execute0 (
        .clk      (clk),
        .arstN    (arstN),
        .decCtl   (decCtl),
        .srcReg   (srcReg),
        .srcData  (srcData),
        .accData  (accData),
        .curFlags (curFlags),
        .exRes    (exRes)
    );

    z80Result result0 (
        .clk      (clk),
        .arstN    (arstN),
        .exRes    (exRes),
        .srcReg   (srcReg),
        .srcData  (srcData),
        .accData  (accData),
        .curFlags (curFlags),
        .res      (res)
    );

endmodule

// File: verification/aluSliceTb.sv
// testbench for the ALU slice: reads instruction vectors and checks every pipelined result
module aluSliceTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 20;
    localparam int maxVec = 64;
    localparam int latency = 3;

    logic            clk;
    logic            arstN;
    logic            instrValid;
    isaPkg::opcodeT  instr;
    isaPkg::byteT    imm;
    corePkg::resultT res;

    string           vecName [maxVec];
    isaPkg::opcodeT  vecOp [maxVec];
    isaPkg::byteT    vecImm [maxVec];
    corePkg::resultT vecExp [maxVec];
    bit              vecTight [maxVec];
    int              vecCount = 0;
    bit              loaded = 1'b0;
    int              cycle = 0;

    // instructions in flight with the oldest first
    string           nameQ [$];
    int              issueQ [$];
    corePkg::resultT expQ [$];

    z80AluSlice dut0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .imm        (imm),
        .res        (res)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    task automatic failRun(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkRegWrite(string name, logic expWrite, isaPkg::regIdxT expReg,
                                 isaPkg::byteT expData);
        if (res.regWrite !== expWrite) begin
            failRun($sformatf("MISMATCH %s regWrite expected %0b actual %0b",
                              name, expWrite, res.regWrite));
        end
        if (expWrite && res.regIdx !== expReg) begin
            failRun($sformatf("MISMATCH %s reg expected %0d actual %0d",
                              name, expReg, res.regIdx));
        end
        if (expWrite && res.data !== expData) begin
            failRun($sformatf("MISMATCH %s data expected %02h actual %02h",
                              name, expData, res.data));
        end
    endtask

    task automatic checkFlags(string name, logic expWrite, corePkg::flagsT expFlags);
        if (res.flagWrite !== expWrite) begin
            failRun($sformatf("MISMATCH %s flagWrite expected %0b actual %0b",
                              name, expWrite, res.flagWrite));
        end
        // flags shown as S Z H PV N C
        if (expWrite && res.flags !== expFlags) begin
            failRun($sformatf("MISMATCH %s flags expected %06b actual %06b",
                              name, expFlags, res.flags));
        end
    endtask

    task automatic checkJump(string name, logic expJump, isaPkg::byteT expTarget);
        if (res.jump !== expJump) begin
            failRun($sformatf("MISMATCH %s jump expected %0b actual %0b",
                              name, expJump, res.jump));
        end
        if (expJump && res.target !== expTarget) begin
            failRun($sformatf("MISMATCH %s target expected %02h actual %02h",
                              name, expTarget, res.target));
        end
    endtask

    // outputs change on the rising edge, so they are read at the falling edge
    task automatic checkOutputs();
        string           name;
        int              issued;
        corePkg::resultT exp;
        if (res.valid === 1'b1) begin
            if (expQ.size() == 0) begin
                failRun("res.valid went high with no instruction in flight");
            end
            name = nameQ.pop_front();
            issued = issueQ.pop_front();
            exp = expQ.pop_front();
            if (issued + latency != cycle) begin
                failRun($sformatf("result of %s arrived %0d cycles after issue",
                                  name, cycle - issued));
            end
            checkRegWrite(name, exp.regWrite, exp.regIdx, exp.data);
            checkFlags(name, exp.flagWrite, exp.flags);
            checkJump(name, exp.jump, exp.target);
        end else if (res.valid !== 1'b0) begin
            failRun("res.valid is unknown");
        end else if (expQ.size() != 0 && issueQ[0] + latency <= cycle) begin
            failRun($sformatf("no result for %s after %0d cycles", nameQ[0], latency));
        end
    endtask

    task automatic nextCycle();
        @(negedge clk);
        cycle++;
        checkOutputs();
    endtask

    task automatic issue(int i);
        instrValid = 1'b1;
        instr = vecOp[i];
        imm = vecImm[i];
        nameQ.push_back(vecName[i]);
        issueQ.push_back(cycle);
        expQ.push_back(vecExp[i]);
        nextCycle();
        instrValid = 1'b0;
        instr = '0;
        imm = '0;
    endtask

    task automatic readVectors();
        int              fd;
        int              n;
        string           line;
        string           name;
        logic [7:0]      op;
        logic [7:0]      iv;
        logic [7:0]      data;
        logic [7:0]      tgt;
        logic [5:0]      fl;
        int              rw;
        int              rg;
        int              fw;
        int              jp;
        int              tight;
        corePkg::resultT exp;
        fd = $fopen("verification/aluSliceVectors.txt", "r");
        if (fd == 0) begin
            failRun("cannot open verification/aluSliceVectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 3 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %d %d %h %d %b %d %h %d",
                        name, op, iv, rw, rg, data, fw, fl, jp, tgt, tight);
            if (n != 11 || vecCount >= maxVec) begin
                failRun($sformatf("bad or surplus vector line: %s", line));
            end
            exp = '0;
            exp.valid = 1'b1;
            exp.regWrite = rw[0];
            exp.regIdx = isaPkg::regIdxT'(rg[2:0]);
            exp.data = data;
            exp.flagWrite = fw[0];
            exp.flags = corePkg::flagsT'(fl);
            exp.jump = jp[0];
            exp.target = tgt;
            vecName[vecCount] = name;
            vecOp[vecCount] = op;
            vecImm[vecCount] = iv;
            vecExp[vecCount] = exp;
            vecTight[vecCount] = tight[0];
            vecCount++;
        end
        $fclose(fd);
    endtask

    // worst case is three idle cycles per vector plus the pipeline drain
    initial begin
        wait (loaded);
        #((vecCount * 8 + 20) * clkPeriod);
        failRun("watchdog expired before the run finished");
    end

    initial begin
        int gap;
        arstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        imm = '0;
        void'($urandom(24));
        readVectors();
        loaded = 1'b1;
        repeat (2) begin
            @(negedge clk);
        end
        arstN = 1'b1;
        // no result may come out while idle after reset
        repeat (5) begin
            nextCycle();
        end
        for (int i = 0; i < vecCount; i++) begin
            if (!vecTight[i]) begin
                gap = 1 + ($urandom % 3);
                repeat (gap) begin
                    nextCycle();
                end
            end
            issue(i);
        end
        repeat (latency + 1) begin
            nextCycle();
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// File: src.f
hw/isaPkg.sv
hw/corePkg.sv
hw/z80Decode.sv
hw/z80Execute.sv
hw/z80Result.sv
hw/z80AluSlice.sv
verification/aluSliceTb.sv

// File: verification/aluSliceVectors.txt
# name opcode imm regWrite reg data flagWrite flags jump target tight
# hex bytes, flags in binary as S Z H PV N C, tight=1 issues in the cycle after the line above
ld_a_42     3E 42 1 7 42 0 000000 0 00 0
cp_a_42     FE 42 0 7 00 1 010010 0 00 1
or_a_00     F6 00 1 7 42 1 000100 0 00 0
ld_b_11     06 11 1 0 11 0 000000 0 00 0
ld_c_22     0E 22 1 1 22 0 000000 0 00 1
ld_d_33     16 33 1 2 33 0 000000 0 00 1
ld_e_44     1E 44 1 3 44 0 000000 0 00 0
ld_h_55     26 55 1 4 55 0 000000 0 00 1
ld_l_66     2E 66 1 5 66 0 000000 0 00 0
ld_a_7f     3E 7F 1 7 7F 0 000000 0 00 1
ld_b_01     06 01 1 0 01 0 000000 0 00 1
add_a_b     80 00 1 7 80 1 101100 0 00 1
ld_a_ff     3E FF 1 7 FF 0 000000 0 00 0
add_a_01    C6 01 1 7 00 1 011001 0 00 1
adc_a_00    CE 00 1 7 01 1 000000 0 00 1
ld_a_00     3E 00 1 7 00 0 000000 0 00 0
sub_a_01    D6 01 1 7 FF 1 101011 0 00 1
sbc_a_7f    DE 7F 1 7 7F 1 001110 0 00 1
ld_a_80     3E 80 1 7 80 0 000000 0 00 0
ld_c_01     0E 01 1 1 01 0 000000 0 00 0
sub_a_c     91 00 1 7 7F 1 001110 0 00 0
cp_a_80     FE 80 0 7 00 1 100111 0 00 1
adc_a_c     89 00 1 7 81 1 101100 0 00 1
ld_d_0f     16 0F 1 2 0F 0 000000 0 00 0
ld_a_3c     3E 3C 1 7 3C 0 000000 0 00 0
cp_a_40     FE 40 0 7 00 1 100011 0 00 1
and_a_d     A2 00 1 7 0C 1 001100 0 00 1
xor_a_ff    EE FF 1 7 F3 1 100100 0 00 1
or_a_e      B3 00 1 7 F7 1 100000 0 00 0
xor_a_a     AF 00 1 7 00 1 010100 0 00 1
jp_z        CA 10 0 0 00 0 000000 1 10 1
or_a_01     F6 01 1 7 01 1 000000 0 00 0
jp_nz       C2 20 0 0 00 0 000000 1 20 1
cp_a_02     FE 02 0 0 00 1 101011 0 00 0
jp_nc       D2 30 0 0 00 0 000000 0 00 1
sub_a_00    D6 00 1 7 01 1 000010 0 00 0
jp_c        DA 40 0 0 00 0 000000 0 00 1
and_a_03    E6 03 1 7 01 1 001000 0 00 0
jp_po       E2 50 0 0 00 0 000000 1 50 1
or_a_02     F6 02 1 7 03 1 000100 0 00 0
jp_pe       EA 60 0 0 00 0 000000 1 60 1
add_a_7f    C6 7F 1 7 82 1 101100 0 00 0
jp_p        F2 70 0 0 00 0 000000 0 00 1
sub_a_01b   D6 01 1 7 81 1 100010 0 00 0
jp_m        FA 80 0 0 00 0 000000 1 80 1
ld_a_10     3E 10 1 7 10 0 000000 0 00 0
add_a_10    C6 10 1 7 20 1 000000 0 00 1
add_a_a     87 00 1 7 40 1 000000 0 00 1
add_a_a2    87 00 1 7 80 1 100100 0 00 1
halt_none   76 00 0 0 00 0 000000 0 00 0
add_hl_none 86 00 0 0 00 0 000000 0 00 1
or_a_00b    F6 00 1 7 80 1 100000 0 00 1
